// File: list.f
+incdir+rtl
rtl/apb_pkg.sv
rtl/soc_periph_pkg.sv
rtl/edge_sync.sv
rtl/periph_bus_decoder.sv
rtl/apb_soc_ctrl.sv
rtl/apb_gpio.sv
rtl/soc_peripherals.sv
bench/soc_periph_assertions.sv
bench/tb_soc_peripherals.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_soc_peripherals \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_soc_peripherals 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Regression passed" && exit 0 || exit 1

// File: bench/tb_soc_peripherals.sv
/* peripheral subsystem testbench */

`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defs.svh"

module tb_soc_peripherals;

  localparam int          CLK_PERIOD      = 10;
  // twice the estimated run length
  localparam int          WATCHDOG_CYCLES = 2 * 1500;
  // odd, so rises and falls differ in count
  localparam int          REF_TOGGLES     = 7;
  localparam logic [31:0] GPIO_BASE       = 32'h0000_0000;
  localparam logic [31:0] CTRL_BASE       = 32'h0000_1000;
  // page 5 decodes to no target
  localparam logic [31:0] HOLE_BASE       = 32'h0000_5000;

  logic                        clk_i = 1'b0;
  logic                        arst_n_i;
  apb_pkg::apb_req_t           apb_req_i;
  logic                        slow_clk_i;
  logic                        bootsel_i;
  logic                        fc_fetch_en_valid_i;
  logic                        fc_fetch_en_i;
  logic [`JTAG_REG_WIDTH-1:0]  soc_jtag_reg_i;
  logic [`N_GPIO-1:0]          gpio_in_i;
  apb_pkg::apb_rsp_t           apb_rsp_o;
  logic [`APB_DATA_WIDTH-1:0]  fc_bootaddr_o;
  logic                        fc_fetchen_o;
  logic [`JTAG_REG_WIDTH-1:0]  soc_jtag_reg_o;
  logic [`N_GPIO-1:0]          gpio_out_o;
  logic [`N_GPIO-1:0]          gpio_oe_o;
  soc_periph_pkg::soc_events_t events_o;

  // expected register state
  logic [31:0] model_boot;
  logic        model_fetch;
  logic [7:0]  model_jtag;
  logic [31:0] model_out;
  logic [31:0] model_oe;

  int checks;
  int errors;
  int test_errors;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  soc_peripherals dut_i (.*);

  bind soc_peripherals soc_periph_assertions i_soc_periph_assertions (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .apb_req_i   (apb_req_i),
    .apb_rsp_i   (apb_rsp_o),
    .fc_fetchen_i(fc_fetchen_o),
    .events_i    (events_o)
  );

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [7:0] offset);
    return base | {24'h0, offset};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  // setup then access, response sampled mid access cycle
  task automatic apb_xfer(input logic [31:0] addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int wait_cycles;
    wait_cycles = 0;
    @(posedge clk_i);
    apb_req_i.paddr   <= addr;
    apb_req_i.pwdata  <= wdata;
    apb_req_i.pwrite  <= write;
    apb_req_i.psel    <= 1'b1;
    apb_req_i.penable <= 1'b0;
    @(posedge clk_i);
    apb_req_i.penable <= 1'b1;
    @(negedge clk_i);
    while (!apb_rsp_o.pready && wait_cycles < 16) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    if (!apb_rsp_o.pready) begin
      $display("no pready from the DUT within 16 cycles at address 0x%h", addr);
      errors++;
      test_errors++;
    end
    rdata = apb_rsp_o.prdata;
    err   = apb_rsp_o.pslverr;
    @(posedge clk_i);
    apb_req_i.psel    <= 1'b0;
    apb_req_i.penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(addr, 1'b1, data, rdata, err);
    check_value("pslverr", 32'(err), 32'h0);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(addr, 1'b0, 32'h0, rdata, err);
    check_value(name, rdata, exp);
    check_value("pslverr", 32'(err), 32'h0);
  endtask

  task automatic check_outputs();
    @(negedge clk_i);
    check_value("fc_bootaddr_o", fc_bootaddr_o, model_boot);
    check_value("fc_fetchen_o", 32'(fc_fetchen_o), 32'(model_fetch));
    check_value("soc_jtag_reg_o", 32'(soc_jtag_reg_o), 32'(model_jtag));
    check_value("gpio_out_o", gpio_out_o, model_out);
    check_value("gpio_oe_o", gpio_oe_o, model_oe);
  endtask

  task automatic count_ref_pulses(inout int rises, inout int falls);
    @(negedge clk_i);
    if (events_o.ref_rise) rises++;
    if (events_o.ref_fall) falls++;
  endtask

  ////////////////////
  // directed tests
  ////////////////////
  task automatic test_reset_values();
    check_outputs();
    check_value("events_o.gpio", events_o.gpio, 32'h0);
    check_value("events_o.ref", 32'({events_o.ref_rise, events_o.ref_fall}), 32'h0);
    read_expect("REG_BOOT_ADDR", reg_addr(CTRL_BASE, soc_periph_pkg::REG_BOOT_ADDR),
                `BOOT_ADDR_RESET);
    read_expect("REG_FETCH_EN", reg_addr(CTRL_BASE, soc_periph_pkg::REG_FETCH_EN), 32'h0);
    read_expect("REG_JTAG", reg_addr(CTRL_BASE, soc_periph_pkg::REG_JTAG), 32'h0);
    read_expect("REG_BOOTSEL", reg_addr(CTRL_BASE, soc_periph_pkg::REG_BOOTSEL), 32'h0);
    read_expect("REG_DIR", reg_addr(GPIO_BASE, soc_periph_pkg::REG_DIR), 32'h0);
    read_expect("REG_IN", reg_addr(GPIO_BASE, soc_periph_pkg::REG_IN), 32'h0);
    read_expect("REG_OUT", reg_addr(GPIO_BASE, soc_periph_pkg::REG_OUT), 32'h0);
    read_expect("REG_INTEN", reg_addr(GPIO_BASE, soc_periph_pkg::REG_INTEN), 32'h0);
    finish_test("reset_values");
  endtask

  task automatic test_soc_ctrl();
    logic [7:0] jtag_in;
    model_boot = $urandom();
    model_jtag = 8'($urandom());
    jtag_in    = 8'($urandom());
    write_reg(reg_addr(CTRL_BASE, soc_periph_pkg::REG_BOOT_ADDR), model_boot);
    write_reg(reg_addr(CTRL_BASE, soc_periph_pkg::REG_JTAG), {24'h0, model_jtag});
    soc_jtag_reg_i <= jtag_in;
    check_outputs();
    read_expect("REG_BOOT_ADDR", reg_addr(CTRL_BASE, soc_periph_pkg::REG_BOOT_ADDR),
                model_boot);
    // incoming byte sits above the outgoing one
    read_expect("REG_JTAG", reg_addr(CTRL_BASE, soc_periph_pkg::REG_JTAG),
                {16'h0, jtag_in, model_jtag});
    bootsel_i <= 1'b1;
    read_expect("REG_BOOTSEL", reg_addr(CTRL_BASE, soc_periph_pkg::REG_BOOTSEL), 32'h1);
    bootsel_i <= 1'b0;
    read_expect("REG_BOOTSEL", reg_addr(CTRL_BASE, soc_periph_pkg::REG_BOOTSEL), 32'h0);
    finish_test("soc_ctrl");
  endtask

  task automatic test_fetch_strobe();
    // strobe alone, loads at the next edge
    @(posedge clk_i);
    fc_fetch_en_valid_i <= 1'b1;
    fc_fetch_en_i       <= 1'b1;
    @(posedge clk_i);
    fc_fetch_en_valid_i <= 1'b0;
    model_fetch = 1'b1;
    check_outputs();
    write_reg(reg_addr(CTRL_BASE, soc_periph_pkg::REG_FETCH_EN), 32'h0);
    model_fetch = 1'b0;
    check_outputs();
    // strobe held across the whole write, bus value loses
    @(posedge clk_i);
    fc_fetch_en_valid_i <= 1'b1;
    fc_fetch_en_i       <= 1'b1;
    write_reg(reg_addr(CTRL_BASE, soc_periph_pkg::REG_FETCH_EN), 32'h0);
    fc_fetch_en_valid_i <= 1'b0;
    model_fetch = 1'b1;
    check_outputs();
    read_expect("REG_FETCH_EN", reg_addr(CTRL_BASE, soc_periph_pkg::REG_FETCH_EN), 32'h1);
    finish_test("fetch_strobe");
  endtask

  task automatic test_gpio();
    logic [31:0] pins;
    logic [31:0] mask;
    logic [31:0] once;
    logic [31:0] repeated;
    int          cnt [`N_GPIO];
    model_oe  = $urandom();
    model_out = $urandom();
    pins      = $urandom();
    mask      = $urandom();
    cnt       = '{default: 0};
    write_reg(reg_addr(GPIO_BASE, soc_periph_pkg::REG_DIR), model_oe);
    write_reg(reg_addr(GPIO_BASE, soc_periph_pkg::REG_OUT), model_out);
    gpio_in_i <= pins;
    check_outputs();
    // two sync flops before the pins are readable
    repeat (2) @(posedge clk_i);
    read_expect("REG_IN", reg_addr(GPIO_BASE, soc_periph_pkg::REG_IN), pins);
    gpio_in_i <= '0;
    write_reg(reg_addr(GPIO_BASE, soc_periph_pkg::REG_INTEN), mask);
    repeat (4) @(posedge clk_i);
    // every pin rises at once
    gpio_in_i <= '1;
    repeat (6) begin
      @(negedge clk_i);
      for (int b = 0; b < `N_GPIO; b++) begin
        if (events_o.gpio[b]) cnt[b]++;
      end
    end
    for (int b = 0; b < `N_GPIO; b++) begin
      once[b]     = (cnt[b] == 1);
      repeated[b] = (cnt[b] > 1);
    end
    check_value("events_o.gpio single pulse", once, mask);
    check_value("events_o.gpio repeated pulse", repeated, 32'h0);
    finish_test("gpio");
  endtask

  task automatic test_ref_clock();
    int   rises;
    int   falls;
    int   exp_rises;
    int   exp_falls;
    int   hold;
    logic level;
    rises     = 0;
    falls     = 0;
    exp_rises = 0;
    exp_falls = 0;
    level     = 1'b0;
    for (int t = 0; t < REF_TOGGLES; t++) begin
      @(posedge clk_i);
      level = ~level;
      slow_clk_i <= level;
      if (level) exp_rises++;
      else exp_falls++;
      // slow clock phase of 3 to 6 cycles
      hold = 3 + int'($urandom() % 4);
      repeat (hold) count_ref_pulses(rises, falls);
    end
    // drain the synchronizer
    repeat (6) count_ref_pulses(rises, falls);
    check_value("events_o.ref_rise count", rises, exp_rises);
    check_value("events_o.ref_fall count", falls, exp_falls);
    finish_test("ref_clock");
  endtask

  task automatic test_unmapped();
    logic [31:0] rdata;
    logic        err;
    apb_xfer(reg_addr(HOLE_BASE, soc_periph_pkg::REG_BOOT_ADDR), 1'b1, $urandom(), rdata, err);
    check_value("pslverr", 32'(err), 32'h1);
    apb_xfer(reg_addr(HOLE_BASE, soc_periph_pkg::REG_OUT), 1'b1, $urandom(), rdata, err);
    check_value("pslverr", 32'(err), 32'h1);
    apb_xfer(reg_addr(HOLE_BASE, soc_periph_pkg::REG_JTAG), 1'b0, 32'h0, rdata, err);
    check_value("pslverr", 32'(err), 32'h1);
    check_value("prdata", rdata, 32'h0);
    // nothing moved
    check_outputs();
    finish_test("unmapped");
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    // one seed for the whole run
    void'($urandom(32'h7de7));
    arst_n_i            <= 1'b0;
    apb_req_i           <= '0;
    slow_clk_i          <= 1'b0;
    bootsel_i           <= 1'b0;
    fc_fetch_en_valid_i <= 1'b0;
    fc_fetch_en_i       <= 1'b0;
    soc_jtag_reg_i      <= '0;
    gpio_in_i           <= '0;
    model_boot  = `BOOT_ADDR_RESET;
    model_fetch = 1'b0;
    model_jtag  = 8'h0;
    model_out   = 32'h0;
    model_oe    = 32'h0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    test_reset_values();
    test_soc_ctrl();
    test_fetch_strobe();
    test_gpio();
    test_ref_clock();
    test_unmapped();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/soc_periph_assertions.sv
/* apb and event assertions */

`timescale 1ns/1ps
`default_nettype none

module soc_periph_assertions (
  input wire logic                  clk_i,
  input wire logic                  arst_n_i,
  input apb_pkg::apb_req_t          apb_req_i,
  input apb_pkg::apb_rsp_t          apb_rsp_i,
  input wire logic                  fc_fetchen_i,
  input soc_periph_pkg::soc_events_t events_i
);

  // slave error only with psel and penable
  a_slverr_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable))
    else $error("pslverr raised outside the access phase");

  // zero wait, every access cycle completes
  a_ready_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_i.pready)
    else $error("pready low in an access cycle");

  // one slow clock edge at a time
  a_ref_edges_apart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(events_i.ref_rise && events_i.ref_fall))
    else $error("ref_rise and ref_fall high together");

  // fc stays parked under reset
  a_fetch_off_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> !fc_fetchen_i)
    else $error("fc_fetchen_o high during reset");

endmodule

`default_nettype wire

// File: rtl/soc_peripherals.sv
/* apb peripheral subsystem */

`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defs.svh"

module soc_peripherals (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  apb_pkg::apb_req_t               apb_req_i,
  input  wire logic                       slow_clk_i,
  input  wire logic                       bootsel_i,
  input  wire logic                       fc_fetch_en_valid_i,
  input  wire logic                       fc_fetch_en_i,
  input  wire logic [`JTAG_REG_WIDTH-1:0] soc_jtag_reg_i,
  input  wire logic [`N_GPIO-1:0]         gpio_in_i,
  output apb_pkg::apb_rsp_t               apb_rsp_o,
  output logic      [`APB_DATA_WIDTH-1:0] fc_bootaddr_o,
  output logic                            fc_fetchen_o,
  output logic      [`JTAG_REG_WIDTH-1:0] soc_jtag_reg_o,
  output logic      [`N_GPIO-1:0]         gpio_out_o,
  output logic      [`N_GPIO-1:0]         gpio_oe_o,
  output soc_periph_pkg::soc_events_t     events_o
);

  apb_pkg::apb_req_t          gpio_req;
  apb_pkg::apb_req_t          soc_ctrl_req;
  logic [`APB_DATA_WIDTH-1:0] gpio_rdata;
  logic [`APB_DATA_WIDTH-1:0] soc_ctrl_rdata;
  logic [`N_GPIO-1:0]         gpio_event;
  logic                       ref_rise;
  logic                       ref_fall;

  ////////////////////
  // bus split
  ////////////////////
  periph_bus_decoder i_periph_bus_decoder (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .apb_req_i       (apb_req_i),
    .gpio_rdata_i    (gpio_rdata),
    .soc_ctrl_rdata_i(soc_ctrl_rdata),
    .gpio_req_o      (gpio_req),
    .soc_ctrl_req_o  (soc_ctrl_req),
    .apb_rsp_o       (apb_rsp_o)
  );

  ////////////////////
  // peripherals
  ////////////////////
  apb_soc_ctrl i_apb_soc_ctrl (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .apb_req_i          (soc_ctrl_req),
    .bootsel_i          (bootsel_i),
    .fc_fetch_en_valid_i(fc_fetch_en_valid_i),
    .fc_fetch_en_i      (fc_fetch_en_i),
    .soc_jtag_reg_i     (soc_jtag_reg_i),
    .prdata_o           (soc_ctrl_rdata),
    .fc_bootaddr_o      (fc_bootaddr_o),
    .fc_fetchen_o       (fc_fetchen_o),
    .soc_jtag_reg_o     (soc_jtag_reg_o)
  );

  apb_gpio i_apb_gpio (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .apb_req_i   (gpio_req),
    .gpio_in_i   (gpio_in_i),
    .prdata_o    (gpio_rdata),
    .gpio_out_o  (gpio_out_o),
    .gpio_oe_o   (gpio_oe_o),
    .gpio_event_o(gpio_event)
  );

  // slow clock edges as events
  edge_sync #(
    .WIDTH(1)
  ) i_ref_clk_sync (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .async_i (slow_clk_i),
    .sync_o  (),
    .rise_o  (ref_rise),
    .fall_o  (ref_fall)
  );

  // event bundle
  assign events_o.gpio     = gpio_event;
  assign events_o.ref_rise = ref_rise;
  assign events_o.ref_fall = ref_fall;

endmodule

`default_nettype wire

// File: rtl/apb_gpio.sv
/* gpio registers and pin events */

`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defs.svh"

module apb_gpio (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  apb_pkg::apb_req_t               apb_req_i,
  input  wire logic [`N_GPIO-1:0]         gpio_in_i,
  output logic      [`APB_DATA_WIDTH-1:0] prdata_o,
  output logic      [`N_GPIO-1:0]         gpio_out_o,
  output logic      [`N_GPIO-1:0]         gpio_oe_o,
  output logic      [`N_GPIO-1:0]         gpio_event_o
);

  localparam int unsigned OFFSET_W = $bits(soc_periph_pkg::gpio_reg_e);

  soc_periph_pkg::gpio_reg_e reg_sel;
  logic                      reg_hit;
  logic                      wr_en;

  logic [`N_GPIO-1:0] dir_q;
  logic [`N_GPIO-1:0] out_q;
  logic [`N_GPIO-1:0] inten_q;
  logic [`N_GPIO-1:0] gpio_sync;
  logic [`N_GPIO-1:0] gpio_rise;

  assign reg_sel = soc_periph_pkg::gpio_reg_e'(apb_req_i.paddr[OFFSET_W-1:0]);
  assign reg_hit = ~|apb_req_i.paddr[`PAGE_LSB-1:OFFSET_W];
  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & reg_hit;

  // pads are asynchronous to clk_i
  edge_sync #(
    .WIDTH(`N_GPIO)
  ) i_gpio_sync (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .async_i (gpio_in_i),
    .sync_o  (gpio_sync),
    .rise_o  (gpio_rise),
    .fall_o  ()
  );

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q   <= '0;
      out_q   <= '0;
      inten_q <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        soc_periph_pkg::REG_DIR:   dir_q   <= apb_req_i.pwdata[`N_GPIO-1:0];
        soc_periph_pkg::REG_OUT:   out_q   <= apb_req_i.pwdata[`N_GPIO-1:0];
        soc_periph_pkg::REG_INTEN: inten_q <= apb_req_i.pwdata[`N_GPIO-1:0];
        // REG_IN is read only
        default: ;
      endcase
    end
  end

  // read back
  always_comb begin
    prdata_o = '0;
    if (reg_hit) begin
      case (reg_sel)
        soc_periph_pkg::REG_DIR:   prdata_o[`N_GPIO-1:0] = dir_q;
        soc_periph_pkg::REG_IN:    prdata_o[`N_GPIO-1:0] = gpio_sync;
        soc_periph_pkg::REG_OUT:   prdata_o[`N_GPIO-1:0] = out_q;
        soc_periph_pkg::REG_INTEN: prdata_o[`N_GPIO-1:0] = inten_q;
        default: ;
      endcase
    end
  end

  assign gpio_out_o   = out_q;
  assign gpio_oe_o    = dir_q;
  // rising edges on enabled pins only
  assign gpio_event_o = gpio_rise & inten_q;

endmodule

`default_nettype wire

// File: rtl/apb_soc_ctrl.sv
/* soc control registers */

`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defs.svh"

module apb_soc_ctrl (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  apb_pkg::apb_req_t               apb_req_i,
  input  wire logic                       bootsel_i,
  input  wire logic                       fc_fetch_en_valid_i,
  input  wire logic                       fc_fetch_en_i,
  input  wire logic [`JTAG_REG_WIDTH-1:0] soc_jtag_reg_i,
  output logic      [`APB_DATA_WIDTH-1:0] prdata_o,
  output logic      [`APB_DATA_WIDTH-1:0] fc_bootaddr_o,
  output logic                            fc_fetchen_o,
  output logic      [`JTAG_REG_WIDTH-1:0] soc_jtag_reg_o
);

  localparam int unsigned OFFSET_W = $bits(soc_periph_pkg::soc_ctrl_reg_e);

  soc_periph_pkg::soc_ctrl_reg_e reg_sel;
  logic                          reg_hit;
  logic                          wr_en;

  logic [`APB_DATA_WIDTH-1:0] boot_addr_q;
  logic                       fetch_en_q;
  logic [`JTAG_REG_WIDTH-1:0] jtag_q;

  // word offset inside the page
  assign reg_sel = soc_periph_pkg::soc_ctrl_reg_e'(apb_req_i.paddr[OFFSET_W-1:0]);
  // bits between offset and page must be zero, no aliasing
  assign reg_hit = ~|apb_req_i.paddr[`PAGE_LSB-1:OFFSET_W];
  // write lands at the end of the access cycle
  assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & reg_hit;

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= `BOOT_ADDR_RESET;
      fetch_en_q  <= 1'b0;
      jtag_q      <= '0;
    end else begin
      if (wr_en) begin
        case (reg_sel)
          soc_periph_pkg::REG_BOOT_ADDR: boot_addr_q <= apb_req_i.pwdata;
          soc_periph_pkg::REG_JTAG:      jtag_q      <= apb_req_i.pwdata[`JTAG_REG_WIDTH-1:0];
          default: ;
        endcase
      end
      // external strobe beats a bus write
      if (fc_fetch_en_valid_i) begin
        fetch_en_q <= fc_fetch_en_i;
      end else if (wr_en && reg_sel == soc_periph_pkg::REG_FETCH_EN) begin
        fetch_en_q <= apb_req_i.pwdata[0];
      end
    end
  end

  ////////////////////
  // read mux
  ////////////////////
  always_comb begin
    prdata_o = '0;
    if (reg_hit) begin
      case (reg_sel)
        soc_periph_pkg::REG_BOOT_ADDR: prdata_o = boot_addr_q;
        soc_periph_pkg::REG_FETCH_EN:  prdata_o[0] = fetch_en_q;
        // incoming byte above outgoing byte
        soc_periph_pkg::REG_JTAG:
          prdata_o[2*`JTAG_REG_WIDTH-1:0] = {soc_jtag_reg_i, jtag_q};
        soc_periph_pkg::REG_BOOTSEL:   prdata_o[0] = bootsel_i;
        default: ;
      endcase
    end
  end

  assign fc_bootaddr_o  = boot_addr_q;
  assign fc_fetchen_o   = fetch_en_q;
  assign soc_jtag_reg_o = jtag_q;

endmodule

`default_nettype wire

// File: rtl/periph_bus_decoder.sv
/* apb page decoder */

`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defs.svh"

module periph_bus_decoder (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  apb_pkg::apb_req_t               apb_req_i,
  input  wire logic [`APB_DATA_WIDTH-1:0] gpio_rdata_i,
  input  wire logic [`APB_DATA_WIDTH-1:0] soc_ctrl_rdata_i,
  output apb_pkg::apb_req_t               gpio_req_o,
  output apb_pkg::apb_req_t               soc_ctrl_req_o,
  output apb_pkg::apb_rsp_t               apb_rsp_o
);

  // decode is purely combinational, clk_i and arst_n_i only complete the port set

  logic [`PAGE_WIDTH-1:0]  page;
  apb_pkg::periph_target_e target;
  logic                    access;

  assign page   = apb_req_i.paddr[`PAGE_LSB +: `PAGE_WIDTH];
  // second phase of a transfer
  assign access = apb_req_i.psel & apb_req_i.penable;

  ////////////////////
  // page decode
  ////////////////////
  always_comb begin
    case (page)
      `PAGE_GPIO:     target = apb_pkg::TARGET_GPIO;
      `PAGE_SOC_CTRL: target = apb_pkg::TARGET_SOC_CTRL;
      default:        target = apb_pkg::TARGET_NONE;
    endcase
  end

  // same request to both, psel only toward the hit
  always_comb begin
    gpio_req_o          = apb_req_i;
    gpio_req_o.psel     = apb_req_i.psel & (target == apb_pkg::TARGET_GPIO);
    soc_ctrl_req_o      = apb_req_i;
    soc_ctrl_req_o.psel = apb_req_i.psel & (target == apb_pkg::TARGET_SOC_CTRL);
  end

  ////////////////////
  // response merge
  ////////////////////
  always_comb begin
    case (target)
      apb_pkg::TARGET_GPIO:     apb_rsp_o.prdata = gpio_rdata_i;
      apb_pkg::TARGET_SOC_CTRL: apb_rsp_o.prdata = soc_ctrl_rdata_i;
      // unmapped page reads zero
      default:                  apb_rsp_o.prdata = '0;
    endcase
    // all targets are zero wait
    apb_rsp_o.pready  = access;
    // error only in the access phase of a miss
    apb_rsp_o.pslverr = access & (target == apb_pkg::TARGET_NONE);
  end

endmodule

`default_nettype wire

// File: rtl/edge_sync.sv
/* synchronizer with edge pulses */

`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defs.svh"

module edge_sync #(
  parameter int unsigned WIDTH = 1
) (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic [WIDTH-1:0] async_i,
  output logic      [WIDTH-1:0] sync_o,
  output logic      [WIDTH-1:0] rise_o,
  output logic      [WIDTH-1:0] fall_o
);

  // index 0 samples the raw input
  logic [`SYNC_STAGES-1:0][WIDTH-1:0] sync_q;
  // last synchronized value, for edge compare
  logic [WIDTH-1:0]                   prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      sync_q <= {sync_q[`SYNC_STAGES-2:0], async_i};
      prev_q <= sync_o;
    end
  end

  assign sync_o = sync_q[`SYNC_STAGES-1];
  // one cycle wide, one flop apart
  assign rise_o = sync_o & ~prev_q;
  assign fall_o = ~sync_o & prev_q;

endmodule

`default_nettype wire

// File: rtl/soc_periph_pkg.sv
/* peripheral register and event types */

`default_nettype none

`include "soc_periph_defs.svh"

package soc_periph_pkg;

  // soc control word offsets, page relative
  typedef enum logic [7:0] {
    REG_BOOT_ADDR = 8'h04,
    REG_FETCH_EN  = 8'h08,
    REG_JTAG      = 8'h0C,
    REG_BOOTSEL   = 8'h10
  } soc_ctrl_reg_e;

  // gpio word offsets, page relative
  typedef enum logic [7:0] {
    REG_DIR   = 8'h00,
    REG_IN    = 8'h04,
    REG_OUT   = 8'h08,
    REG_INTEN = 8'h0C
  } gpio_reg_e;

  // single cycle event pulses toward the fc
  typedef struct packed {
    logic [`N_GPIO-1:0] gpio;
    logic               ref_rise;
    logic               ref_fall;
  } soc_events_t;

endpackage

`default_nettype wire

// File: rtl/apb_pkg.sv
/* apb bus types */

`default_nettype none

`include "soc_periph_defs.svh"

package apb_pkg;

  // master to slave, one transfer
  typedef struct packed {
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    logic                       pwrite;
    logic                       psel;
    logic                       penable;
  } apb_req_t;

  // slave to master
  typedef struct packed {
    logic [`APB_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
  } apb_rsp_t;

  // page decode result
  typedef enum logic [1:0] {
    TARGET_GPIO     = 2'd0,
    TARGET_SOC_CTRL = 2'd1,
    TARGET_NONE     = 2'd2
  } periph_target_e;

endpackage

`default_nettype wire

// File: rtl/soc_periph_defs.svh
/* peripheral subsystem parameters */

`ifndef SOC_PERIPH_DEFS_SVH
`define SOC_PERIPH_DEFS_SVH

// apb bus widths
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

// page field inside paddr
`define PAGE_LSB 12
`define PAGE_WIDTH 4

// page numbers per target
`define PAGE_GPIO 4'h0
`define PAGE_SOC_CTRL 4'h1

// gpio pin count
`define N_GPIO 32

// jtag exchange byte
`define JTAG_REG_WIDTH 8

// fc boot vector out of reset
`define BOOT_ADDR_RESET 32'h1A00_0080

// flops in each synchronizer chain
`define SYNC_STAGES 2

`endif
